/* queue_cfg.svh */
`ifndef QUEUE_CFG_SVH
`define QUEUE_CFG_SVH

// number of packet buffers, one per buffer number
`define QS_NUM_BUF 4

// entries held by each buffer before the oldest is lost
`define QS_DEPTH 6

// above this level the arbiter favours the highest buffer number on a tie
`define QS_THRESHOLD 3

// width of each statistics counter
`define QS_CNT_W 7

`endif

/* queue_pkg.sv */
`default_nettype none

package queue_pkg;

	// buffer number, selects one of the four queues
	typedef logic [1:0] buf_id_t;

	// packet payload
	typedef logic [1:0] payload_t;

	// packet as it arrives and leaves the switch
	typedef struct packed {
		buf_id_t  buf_id;
		payload_t payload;
	} pkt_t;

	// fill level of one buffer, 0 up to the depth
	typedef logic [2:0] level_t;

	// per buffer tallies
	typedef struct packed {
		logic [6:0] recv_cnt;
		logic [6:0] read_cnt;
		logic [6:0] drop_cnt;
	} buf_stats_t;

	// index 0 is buffer 0
	typedef buf_stats_t [3:0] stats_bus_t;

endpackage

`default_nettype wire

/* packet_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "queue_cfg.svh"

module packet_fifo
	import queue_pkg::*;
#(
	parameter int DEPTH = `QS_DEPTH
) (
	input  wire           clk,
	input  wire           rst_n_i,
	input  wire           push_i,
	input  wire payload_t data_i,
	input  wire           pop_i,
	output level_t        level_o,
	output payload_t      head_o,
	output logic          drop_o
);

	localparam level_t FULL = level_t'(DEPTH);

	// entry 0 is always the oldest packet
	payload_t mem [DEPTH];

	level_t level_q;
	level_t wr_idx;
	logic   pop_ok;
	logic   drop;
	logic   shift;

	// a pop on an empty buffer is ignored
	assign pop_ok = pop_i && (level_q != '0);

	// full and not read this cycle, so the head makes room
	assign drop = push_i && (level_q == FULL) && !pop_ok;

	// both a read and a drop move every entry one place down
	assign shift = pop_ok || drop;

	// new packet lands behind the last valid entry
	assign wr_idx = shift ? level_q - 1'b1 : level_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			level_q <= '0;
		end else begin
			case ({push_i && !drop, pop_ok})
				2'b10: begin
					level_q <= level_q + 1'b1;
				end
				2'b01: begin
					level_q <= level_q - 1'b1;
				end
				default: begin
					// push with pop, push with drop, or idle
					level_q <= level_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (shift) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				mem[i] <= mem[i + 1];
			end
		end
		// written after the shift so it wins on the same slot
		if (push_i) begin
			mem[wr_idx] <= data_i;
		end
	end

	assign level_o = level_q;
	assign head_o  = mem[0];
	assign drop_o  = drop;

endmodule

`default_nettype wire

/* queue_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "queue_cfg.svh"

module queue_arbiter
	import queue_pkg::*;
(
	input  wire                             clk,
	input  wire                             rst_n_i,
	input  wire level_t   [`QS_NUM_BUF-1:0] level_i,
	input  wire payload_t [`QS_NUM_BUF-1:0] head_i,
	input  wire                             out_ready_i,
	output logic          [`QS_NUM_BUF-1:0] pop_o,
	output logic                            out_valid_o,
	output pkt_t                            out_pkt_o
);

	logic    any_busy;
	logic    over_thr;
	buf_id_t sel;
	level_t  best;
	logic    load;
	logic    valid_q;
	pkt_t    pkt_q;

	// overall load picture of the four buffers
	always_comb begin
		any_busy = 1'b0;
		over_thr = 1'b0;
		for (int i = 0; i < `QS_NUM_BUF; i++) begin
			if (level_i[i] != '0) begin
				any_busy = 1'b1;
			end
			if (level_i[i] > level_t'(`QS_THRESHOLD)) begin
				over_thr = 1'b1;
			end
		end
	end

	// fullest buffer wins
	// under heavy load a later buffer takes an equal level,
	// otherwise the first one found keeps it
	always_comb begin
		sel  = '0;
		best = '0;
		for (int i = 0; i < `QS_NUM_BUF; i++) begin
			if (over_thr) begin
				if (level_i[i] >= best) begin
					sel  = buf_id_t'(i);
					best = level_i[i];
				end
			end else if (level_i[i] > best) begin
				sel  = buf_id_t'(i);
				best = level_i[i];
			end
		end
	end

	// output slot is free or being emptied this cycle
	assign load = any_busy && (!valid_q || out_ready_i);

	always_comb begin
		for (int i = 0; i < `QS_NUM_BUF; i++) begin
			pop_o[i] = load && (sel == buf_id_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (out_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	// held while the sink is stalled
	always_ff @(posedge clk) begin
		if (load) begin
			pkt_q.buf_id  <= sel;
			pkt_q.payload <= head_i[sel];
		end
	end

	assign out_valid_o = valid_q;
	assign out_pkt_o   = pkt_q;

endmodule

`default_nettype wire

/* queue_stats.sv */
`timescale 1ns/100ps
`default_nettype none

`include "queue_cfg.svh"

module queue_stats
	import queue_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire [`QS_NUM_BUF-1:0] recv_i,
	input  wire [`QS_NUM_BUF-1:0] read_i,
	input  wire [`QS_NUM_BUF-1:0] drop_i,
	output stats_bus_t            stats_o
);

	localparam logic [`QS_CNT_W-1:0] CNT_MAX = '1;

	stats_bus_t stats_q;

	// stops at the top value rather than wrapping to zero
	function automatic logic [`QS_CNT_W-1:0] sat_inc(
		input logic [`QS_CNT_W-1:0] cnt,
		input logic                 ev
	);
		logic [`QS_CNT_W-1:0] nxt;
		nxt = cnt;
		if (ev && (cnt != CNT_MAX)) begin
			nxt = cnt + 1'b1;
		end
		return nxt;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			stats_q <= '0;
		end else begin
			for (int b = 0; b < `QS_NUM_BUF; b++) begin
				stats_q[b].recv_cnt <= sat_inc(stats_q[b].recv_cnt, recv_i[b]);
				stats_q[b].read_cnt <= sat_inc(stats_q[b].read_cnt, read_i[b]);
				stats_q[b].drop_cnt <= sat_inc(stats_q[b].drop_cnt, drop_i[b]);
			end
		end
	end

	assign stats_o = stats_q;

endmodule

`default_nettype wire

/* queue_switch_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "queue_cfg.svh"

module queue_switch_top
	import queue_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        in_valid_i,
	input  wire pkt_t  in_pkt_i,
	input  wire        out_ready_i,
	output logic       out_valid_o,
	output pkt_t       out_pkt_o,
	output stats_bus_t stats_o
);

	logic     [`QS_NUM_BUF-1:0] push;
	logic     [`QS_NUM_BUF-1:0] pop;
	logic     [`QS_NUM_BUF-1:0] drop;
	level_t   [`QS_NUM_BUF-1:0] level;
	payload_t [`QS_NUM_BUF-1:0] head;

	// buffer number picks exactly one queue per valid packet
	always_comb begin
		for (int i = 0; i < `QS_NUM_BUF; i++) begin
			push[i] = in_valid_i && (in_pkt_i.buf_id == buf_id_t'(i));
		end
	end

	for (genvar g = 0; g < `QS_NUM_BUF; g++) begin : g_buf
		packet_fifo #(
			.DEPTH (`QS_DEPTH)
		) i_packet_fifo (
			.clk     (clk),
			.rst_n_i (rst_n_i),
			.push_i  (push[g]),
			.data_i  (in_pkt_i.payload),
			.pop_i   (pop[g]),
			.level_o (level[g]),
			.head_o  (head[g]),
			.drop_o  (drop[g])
		);
	end

	queue_arbiter i_queue_arbiter (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.level_i     (level),
		.head_i      (head),
		.out_ready_i (out_ready_i),
		.pop_o       (pop),
		.out_valid_o (out_valid_o),
		.out_pkt_o   (out_pkt_o)
	);

	// every push is a received packet, every pop a read
	queue_stats i_queue_stats (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.recv_i  (push),
		.read_i  (pop),
		.drop_i  (drop),
		.stats_o (stats_o)
	);

endmodule

`default_nettype wire

/* tb_queue_checks.svh */
`ifndef TB_QUEUE_CHECKS_SVH
`define TB_QUEUE_CHECKS_SVH

// failures counted by kind
int err_pkt = 0;
int err_stats = 0;
int err_flag = 0;
int err_misc = 0;

task automatic check_pkt(input string name, input pkt_t got, input pkt_t exp);
	if (got !== exp) begin
		err_pkt++;
		$display("[ERROR] %0t %s: got buf %0d payload %0d, expected buf %0d payload %0d",
			$time, name, got.buf_id, got.payload, exp.buf_id, exp.payload);
	end
endtask

task automatic check_stats(input string name, input buf_stats_t got, input buf_stats_t exp);
	if (got !== exp) begin
		err_stats++;
		$display("[ERROR] %0t %s: got recv/read/drop %0d/%0d/%0d, expected %0d/%0d/%0d",
			$time, name, got.recv_cnt, got.read_cnt, got.drop_cnt,
			exp.recv_cnt, exp.read_cnt, exp.drop_cnt);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		err_flag++;
		$display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
	end
endtask

// failures that are not a wrong value
task automatic note_failure(input string what);
	err_misc++;
	$display("failure at %0t: %s", $time, what);
endtask

function automatic int total_errors();
	return err_pkt + err_stats + err_flag + err_misc;
endfunction

task automatic print_counts();
	$display("error counts: packet %0d, statistics %0d, valid %0d, other %0d, total %0d",
		err_pkt, err_stats, err_flag, err_misc, total_errors());
endtask

`endif

/* tb_queue_switch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "queue_cfg.svh"

module tb_queue_switch
	import queue_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS = 6;
	localparam int STEPS_PER_TEST = 260;
	localparam int TIMEOUT_NS = NUM_TESTS * STEPS_PER_TEST * CLK_PERIOD * 2;

	logic       clk = 1'b0;
	logic       rst_n_i = 1'b0;
	logic       in_valid_i = 1'b0;
	pkt_t       in_pkt_i = '0;
	logic       out_ready_i = 1'b0;
	logic       out_valid_o;
	pkt_t       out_pkt_o;
	stats_bus_t stats_o;

	// expected state of the switch, compared at each falling edge
	payload_t   mq [4][$];
	buf_stats_t ms [4];
	logic       mvalid;
	pkt_t       mpkt;
	logic       checking;
	int         seed = 32'h13ae_f309;

	`include "tb_queue_checks.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	queue_switch_top i_queue_switch_top (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_pkt_i    (in_pkt_i),
		.out_ready_i (out_ready_i),
		.out_valid_o (out_valid_o),
		.out_pkt_o   (out_pkt_o),
		.stats_o     (stats_o)
	);

	function automatic logic [6:0] bump(input logic [6:0] c);
		return (c == 7'h7f) ? c : c + 7'd1;
	endfunction

	function automatic buf_stats_t stats_of(input int recv, input int rd, input int drop);
		buf_stats_t s;
		s.recv_cnt = 7'(recv);
		s.read_cnt = 7'(rd);
		s.drop_cnt = 7'(drop);
		return s;
	endfunction

	// fullest buffer, ties high above the threshold and low otherwise
	function automatic int pick_buf();
		int sel;
		int best;
		logic over;
		sel = -1;
		best = 0;
		over = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (mq[i].size() > `QS_THRESHOLD) begin
				over = 1'b1;
			end
		end
		for (int i = 0; i < 4; i++) begin
			if (mq[i].size() > 0) begin
				if (mq[i].size() > best || (over && mq[i].size() == best)) begin
					sel = i;
					best = mq[i].size();
				end
			end
		end
		return sel;
	endfunction

	task automatic model_update(input logic v, input pkt_t p, input logic r);
		int sel;
		int b;
		sel = pick_buf();
		if (sel >= 0 && (!mvalid || r)) begin
			mpkt.buf_id = buf_id_t'(sel);
			mpkt.payload = mq[sel].pop_front();
			ms[sel].read_cnt = bump(ms[sel].read_cnt);
			mvalid = 1'b1;
		end else if (r) begin
			mvalid = 1'b0;
		end
		if (v) begin
			b = p.buf_id;
			ms[b].recv_cnt = bump(ms[b].recv_cnt);
			if (mq[b].size() == `QS_DEPTH) begin
				void'(mq[b].pop_front());
				ms[b].drop_cnt = bump(ms[b].drop_cnt);
			end
			mq[b].push_back(p.payload);
		end
	endtask

	// one clock: drive the inputs, compare the edge just passed, then advance the model
	task automatic step(input logic v, input pkt_t p, input logic r);
		@(posedge clk);
		in_valid_i <= v;
		in_pkt_i <= p;
		out_ready_i <= r;
		@(negedge clk);
		if (checking) begin
			check_flag("out_valid_o", out_valid_o, mvalid);
			if (mvalid) begin
				check_pkt("out_pkt_o", out_pkt_o, mpkt);
			end
			for (int b = 0; b < 4; b++) begin
				check_stats($sformatf("stats_o[%0d]", b), stats_o[b], ms[b]);
			end
		end
		// the new inputs are taken at the next rising edge
		model_update(v, p, r);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n_i <= 1'b0;
		in_valid_i <= 1'b0;
		out_ready_i <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int b = 0; b < 4; b++) begin
			mq[b].delete();
			ms[b] = '0;
		end
		mvalid = 1'b0;
		mpkt = '0;
		checking = 1'b1;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((out_valid_o || mvalid || pick_buf() >= 0) && n < 60) begin
			step(1'b0, '0, 1'b1);
			n++;
		end
		step(1'b0, '0, 1'b1);
		if (out_valid_o) begin
			note_failure("output still valid after draining");
		end
	endtask

	task automatic fill(input int b, input int n);
		for (int i = 0; i < n; i++) begin
			step(1'b1, {buf_id_t'(b), payload_t'(i)}, 1'b0);
		end
	endtask

	task automatic test_pass_through();
		apply_reset();
		step(1'b1, {2'd2, 2'd3}, 1'b1);
		step(1'b0, '0, 1'b1);
		step(1'b0, '0, 1'b1);
		// the packet is visible two edges after its input edge
		check_flag("out_valid_o after two cycles", out_valid_o, 1'b1);
		check_pkt("out_pkt_o pass-through", out_pkt_o, {2'd2, 2'd3});
		drain();
		check_stats("stats_o[2] pass-through", stats_o[2], stats_of(1, 1, 0));
	endtask

	task automatic test_order();
		apply_reset();
		for (int i = 0; i < 5; i++) begin
			step(1'b1, {2'd1, payload_t'(3 - i)}, 1'b1);
		end
		drain();
	endtask

	task automatic test_overflow();
		apply_reset();
		fill(3, 8);
		step(1'b0, '0, 1'b0);
		step(1'b0, '0, 1'b0);
		// first packet went straight to the empty output slot
		check_stats("stats_o[3] overflow", stats_o[3], stats_of(8, 1, 1));
		apply_reset();
		// occupy the output slot so buffer 1 takes all eight
		step(1'b1, {2'd0, 2'd0}, 1'b0);
		fill(1, 8);
		step(1'b0, '0, 1'b0);
		check_stats("stats_o[1] overflow", stats_o[1], stats_of(8, 0, 2));
		drain();
	endtask

	task automatic test_arbitration();
		apply_reset();
		fill(0, 3);
		fill(1, 5);
		fill(2, 5);
		fill(3, 2);
		drain();
		apply_reset();
		fill(3, 1);
		fill(0, 3);
		fill(1, 1);
		fill(2, 3);
		drain();
	endtask

	task automatic test_back_pressure();
		apply_reset();
		fill(2, 4);
		step(1'b0, '0, 1'b0);
		repeat (6) step(1'b0, '0, 1'b0);
		// oldest packet of buffer 2 sits in the stalled output
		check_flag("out_valid_o held", out_valid_o, 1'b1);
		check_pkt("out_pkt_o held", out_pkt_o, {2'd2, 2'd0});
		check_stats("stats_o[2] stalled", stats_o[2], stats_of(4, 1, 0));
		for (int i = 0; i < 8; i++) begin
			step(1'b0, '0, i[0]);
		end
		drain();
	endtask

	task automatic test_random();
		int r;
		apply_reset();
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			step(r[0], pkt_t'(r[4:1]), r[5] | r[6]);
		end
		drain();
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		checking = 1'b0;
		mvalid = 1'b0;
		test_pass_through();
		test_order();
		test_overflow();
		test_arbitration();
		test_back_pressure();
		test_random();
		print_counts();
		if (total_errors() == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* queue_switch_top.f */
+incdir+.
queue_pkg.sv
packet_fifo.sv
queue_arbiter.sv
queue_stats.sv
queue_switch_top.sv
tb_queue_switch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_queue_switch
FILELIST  ?= queue_switch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
